// File: Makefile
TOP := tb_mem_subsystem

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f sources.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

// File: common/mem_bus_pkg.sv
`default_nettype none

package mem_bus_pkg;

    // Region of a CPU address, taken from its top six bits
    // 0 is SDRAM space, 1 is the peripheral window, the rest is unmapped
    typedef enum logic [1:0] {
        region_sdram    = 2'd0,
        region_periph   = 2'd1,
        region_unmapped = 2'd2
    } mem_region_e;

    // Which source owns the memory port while its request waits for ready
    typedef enum logic [1:0] {
        arb_idle = 2'd0,
        arb_data = 2'd1,
        arb_inst = 2'd2
    } arb_state_e;

endpackage

`default_nettype wire

// File: common/mem_bus_settings.svh
`ifndef MEM_BUS_SETTINGS_SVH
`define MEM_BUS_SETTINGS_SVH

// Byte address width of SDRAM space
`define SDRAM_ADDR_BITS 26

// Words in the on-chip stand-in memory, word addresses wrap around it
`define SDRAM_WORDS 1024

// Memory timing in clock cycles
`define SDRAM_READ_LATENCY 4
`define SDRAM_BUSY_CYCLES 2

// Response tag, bit 8 is the source and bits 7:0 are address bits 9:2
`define RTAG_BITS 9

// Peripheral window contents
`define PERIPH_REGS 8
`define DEVICE_ID 32'h5d0c_0001
`define UNMAPPED_DATA 32'hdead_beef

`endif

// File: dcache/cpu_dcache.sv
`timescale 1ns/100ps
`default_nettype none

`include "mem_bus_settings.svh"

module cpu_dcache (
    input  wire logic                        clock,
    input  wire logic                        reset,

    // CPU data port
    input  wire logic                        cpu_request,
    output logic                             cpu_ready,
    input  wire logic                        cpu_write,
    input  wire logic [31:0]                 cpu_address,
    input  wire logic [3:0]                  cpu_wstrb,
    input  wire logic [31:0]                 cpu_wdata,

    // Peripheral decoder, its read data returns on a separate path
    output logic                             dec_request,
    output logic                             dec_write,
    output logic [31:0]                      dec_address,
    output logic [3:0]                       dec_wstrb,
    output logic [31:0]                      dec_wdata,

    // SDRAM arbiter
    output logic                             dcache_sdram_request,
    input  wire logic                        dcache_sdram_ready,
    output logic                             dcache_sdram_write,
    output logic [`SDRAM_ADDR_BITS-1:0]      dcache_sdram_address,
    output logic [3:0]                       dcache_sdram_wstrb,
    output logic [31:0]                      dcache_sdram_wdata,
    input  wire logic                        dcache_sdram_rvalid,
    input  wire logic [31:0]                 dcache_sdram_rdata,
    input  wire logic [`RTAG_BITS-1:0]       dcache_sdram_rtag,

    // SDRAM read responses back to the CPU
    output logic                             cpu_rvalid,
    output logic [31:0]                      cpu_rdata,
    output logic [`RTAG_BITS-1:0]            cpu_rtag
);
    import mem_bus_pkg::*;

    // Request currently held
    logic        held_request;
    logic        held_write;
    logic [31:0] held_address;
    logic [3:0]  held_wstrb;
    logic [31:0] held_wdata;
    mem_region_e held_region;

    // What was offered to the arbiter last cycle
    logic                        prev_sdram_request;
    logic                        prev_sdram_ready;
    logic                        prev_sdram_write;
    logic [`SDRAM_ADDR_BITS-1:0] prev_sdram_address;
    logic [3:0]                  prev_sdram_wstrb;
    logic [31:0]                 prev_sdram_wdata;

    logic sdram_pending;
    logic sdram_offer;
    logic dec_offer;

    always_comb begin
        if (held_address[31:26] == 6'd0) begin
            held_region = region_sdram;
        end else if (held_address[31:26] == 6'd1) begin
            held_region = region_periph;
        end else begin
            held_region = region_unmapped;
        end
    end

    // An offer stays up until the registered ready shows it was taken
    assign sdram_pending = prev_sdram_request && !prev_sdram_ready;
    assign sdram_offer   = held_request && (held_region == region_sdram) && !sdram_pending;
    assign dec_offer     = held_request && (held_region != region_sdram);

    assign cpu_ready = !held_request || dec_offer || sdram_offer;

    // Decoder never stalls
    assign dec_request = dec_offer;
    assign dec_write   = held_write;
    assign dec_address = held_address;
    assign dec_wstrb   = held_wstrb;
    assign dec_wdata   = held_wdata;

    assign dcache_sdram_request = sdram_pending || sdram_offer;
    assign dcache_sdram_write   = sdram_offer ? held_write : prev_sdram_write;
    assign dcache_sdram_address = sdram_offer ? held_address[`SDRAM_ADDR_BITS-1:0]
                                              : prev_sdram_address;
    assign dcache_sdram_wstrb   = sdram_offer ? held_wstrb : prev_sdram_wstrb;
    assign dcache_sdram_wdata   = sdram_offer ? held_wdata : prev_sdram_wdata;

    assign cpu_rvalid = dcache_sdram_rvalid;
    assign cpu_rdata  = dcache_sdram_rdata;
    assign cpu_rtag   = dcache_sdram_rtag;

    always_ff @(posedge clock) begin
        if (reset) begin
            held_request       <= 1'b0;
            prev_sdram_request <= 1'b0;
            prev_sdram_ready   <= 1'b0;
        end else begin
            if (cpu_ready) begin
                held_request <= cpu_request;
            end
            prev_sdram_request <= dcache_sdram_request;
            prev_sdram_ready   <= dcache_sdram_ready;
        end
    end

    always_ff @(posedge clock) begin
        if (cpu_ready) begin
            held_write   <= cpu_write;
            held_address <= cpu_address;
            held_wstrb   <= cpu_wstrb;
            held_wdata   <= cpu_wdata;
        end
        prev_sdram_write   <= dcache_sdram_write;
        prev_sdram_address <= dcache_sdram_address;
        prev_sdram_wstrb   <= dcache_sdram_wstrb;
        prev_sdram_wdata   <= dcache_sdram_wdata;
    end

endmodule

`default_nettype wire

// File: hdl/address_decoder.sv
`timescale 1ns/100ps
`default_nettype none

`include "mem_bus_settings.svh"

module address_decoder (
    input  wire logic        clock,
    input  wire logic        reset,
    input  wire logic        dec_request,
    input  wire logic        dec_write,
    input  wire logic [31:0] dec_address,
    input  wire logic [3:0]  dec_wstrb,
    input  wire logic [31:0] dec_wdata,
    output logic             periph_rvalid,
    output logic [31:0]      periph_rdata
);
    import mem_bus_pkg::*;

    logic [31:0] scratch [`PERIPH_REGS];

    mem_region_e                          region;
    logic [23:0]                          word_offset;
    logic [$clog2(`PERIPH_REGS)-1:0]      reg_index;
    logic                                 scratch_hit;
    logic                                 scratch_write;
    logic [31:0]                          read_value;

    always_comb begin
        if (dec_address[31:26] == 6'd0) begin
            region = region_sdram;
        end else if (dec_address[31:26] == 6'd1) begin
            region = region_periph;
        end else begin
            region = region_unmapped;
        end
    end

    assign word_offset   = dec_address[25:2];
    assign reg_index     = dec_address[$clog2(`PERIPH_REGS)+1:2];
    assign scratch_hit   = (region == region_periph) && (word_offset < `PERIPH_REGS);
    assign scratch_write = dec_request && dec_write && scratch_hit;

    always_comb begin
        read_value = `UNMAPPED_DATA;
        if (region == region_periph) begin
            if (scratch_hit) begin
                read_value = scratch[reg_index];
            end else if (word_offset == `PERIPH_REGS) begin
                read_value = `DEVICE_ID;
            end else begin
                read_value = 32'h0;
            end
        end
    end

    // Writes outside the scratch registers are dropped
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `PERIPH_REGS; i++) begin
                scratch[i] <= 32'h0;
            end
        end else if (scratch_write) begin
            for (int b = 0; b < 4; b++) begin
                if (dec_wstrb[b]) begin
                    scratch[reg_index][8*b +: 8] <= dec_wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            periph_rvalid <= 1'b0;
        end else begin
            periph_rvalid <= dec_request && !dec_write;
        end
        periph_rdata <= read_value;
    end

endmodule

`default_nettype wire

// File: hdl/mem_subsystem_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "mem_bus_settings.svh"

module mem_subsystem_top (
    input  wire logic                        clock,
    input  wire logic                        reset,

    input  wire logic                        cpu_request,
    output logic                             cpu_ready,
    input  wire logic                        cpu_write,
    input  wire logic [31:0]                 cpu_address,
    input  wire logic [3:0]                  cpu_wstrb,
    input  wire logic [31:0]                 cpu_wdata,
    output logic                             cpu_rvalid,
    output logic [31:0]                      cpu_rdata,
    output logic [`RTAG_BITS-1:0]            cpu_rtag,

    input  wire logic                        icache_request,
    output logic                             icache_ready,
    input  wire logic [`SDRAM_ADDR_BITS-1:0] icache_address,
    output logic                             icache_rvalid,
    output logic [31:0]                      icache_rdata,

    output logic                             periph_rvalid,
    output logic [31:0]                      periph_rdata
);

    // Router to decoder
    logic        dec_request;
    logic        dec_write;
    logic [31:0] dec_address;
    logic [3:0]  dec_wstrb;
    logic [31:0] dec_wdata;

    // Router to arbiter
    logic                        dcache_sdram_request;
    logic                        dcache_sdram_ready;
    logic                        dcache_sdram_write;
    logic [`SDRAM_ADDR_BITS-1:0] dcache_sdram_address;
    logic [3:0]                  dcache_sdram_wstrb;
    logic [31:0]                 dcache_sdram_wdata;
    logic                        dcache_sdram_rvalid;
    logic [31:0]                 dcache_sdram_rdata;
    logic [`RTAG_BITS-1:0]       dcache_sdram_rtag;

    // Arbiter to memory
    logic                        mem_request;
    logic                        mem_ready;
    logic                        mem_write;
    logic [`SDRAM_ADDR_BITS-1:0] mem_address;
    logic [3:0]                  mem_wstrb;
    logic [31:0]                 mem_wdata;
    logic [`RTAG_BITS-1:0]       mem_tag;
    logic                        mem_rvalid;
    logic [31:0]                 mem_rdata;
    logic [`RTAG_BITS-1:0]       mem_rtag;

    cpu_dcache i_cpu_dcache (.*);

    address_decoder i_address_decoder (.*);

    sdram_arbiter i_sdram_arbiter (.*);

    sdram_memory i_sdram_memory (.*);

endmodule

`default_nettype wire

// File: sdram/sdram_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

`include "mem_bus_settings.svh"

module sdram_arbiter (
    input  wire logic                        clock,
    input  wire logic                        reset,

    // Data side from the router
    input  wire logic                        dcache_sdram_request,
    output logic                             dcache_sdram_ready,
    input  wire logic                        dcache_sdram_write,
    input  wire logic [`SDRAM_ADDR_BITS-1:0] dcache_sdram_address,
    input  wire logic [3:0]                  dcache_sdram_wstrb,
    input  wire logic [31:0]                 dcache_sdram_wdata,
    output logic                             dcache_sdram_rvalid,
    output logic [31:0]                      dcache_sdram_rdata,
    output logic [`RTAG_BITS-1:0]            dcache_sdram_rtag,

    // Instruction fetch, read only
    input  wire logic                        icache_request,
    output logic                             icache_ready,
    input  wire logic [`SDRAM_ADDR_BITS-1:0] icache_address,
    output logic                             icache_rvalid,
    output logic [31:0]                      icache_rdata,

    // Memory port
    output logic                             mem_request,
    input  wire logic                        mem_ready,
    output logic                             mem_write,
    output logic [`SDRAM_ADDR_BITS-1:0]      mem_address,
    output logic [3:0]                       mem_wstrb,
    output logic [31:0]                      mem_wdata,
    output logic [`RTAG_BITS-1:0]            mem_tag,
    input  wire logic                        mem_rvalid,
    input  wire logic [31:0]                 mem_rdata,
    input  wire logic [`RTAG_BITS-1:0]       mem_rtag
);
    import mem_bus_pkg::*;

    arb_state_e state;
    logic       grant_data;
    logic       grant_inst;

    // A waiting request keeps its grant, otherwise data wins
    always_comb begin
        grant_data = 1'b0;
        grant_inst = 1'b0;
        unique case (state)
            arb_data: grant_data = 1'b1;
            arb_inst: grant_inst = 1'b1;
            default: begin
                if (dcache_sdram_request) begin
                    grant_data = 1'b1;
                end else if (icache_request) begin
                    grant_inst = 1'b1;
                end
            end
        endcase
    end

    assign mem_request = (grant_data && dcache_sdram_request) || (grant_inst && icache_request);
    assign mem_write   = grant_data && dcache_sdram_write;
    assign mem_address = grant_inst ? icache_address : dcache_sdram_address;
    assign mem_wstrb   = dcache_sdram_wstrb;
    assign mem_wdata   = dcache_sdram_wdata;
    assign mem_tag     = {grant_inst, mem_address[9:2]};

    // Ready passes through unless the other side holds the port
    assign dcache_sdram_ready = mem_ready && !grant_inst;
    assign icache_ready       = mem_ready && !grant_data;

    // Tag bit 8 picks the destination of each response
    assign dcache_sdram_rvalid = mem_rvalid && !mem_rtag[8];
    assign dcache_sdram_rdata  = mem_rdata;
    assign dcache_sdram_rtag   = mem_rtag;
    assign icache_rvalid       = mem_rvalid && mem_rtag[8];
    assign icache_rdata        = mem_rdata;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= arb_idle;
        end else if (mem_request && !mem_ready) begin
            state <= grant_inst ? arb_inst : arb_data;
        end else begin
            state <= arb_idle;
        end
    end

endmodule

`default_nettype wire

// File: sdram/sdram_memory.sv
`timescale 1ns/100ps
`default_nettype none

`include "mem_bus_settings.svh"

module sdram_memory (
    input  wire logic                        clock,
    input  wire logic                        reset,
    input  wire logic                        mem_request,
    output logic                             mem_ready,
    input  wire logic                        mem_write,
    input  wire logic [`SDRAM_ADDR_BITS-1:0] mem_address,
    input  wire logic [3:0]                  mem_wstrb,
    input  wire logic [31:0]                 mem_wdata,
    input  wire logic [`RTAG_BITS-1:0]       mem_tag,
    output logic                             mem_rvalid,
    output logic [31:0]                      mem_rdata,
    output logic [`RTAG_BITS-1:0]            mem_rtag
);

    logic [31:0] words [`SDRAM_WORDS];

    logic [$clog2(`SDRAM_WORDS)-1:0]         word_index;
    logic [$clog2(`SDRAM_BUSY_CYCLES+1)-1:0] busy_count;
    logic                                    accept;

    // Read pipeline, one stage per cycle of latency
    logic [`SDRAM_READ_LATENCY-1:0] valid_pipe;
    logic [31:0]                    data_pipe [`SDRAM_READ_LATENCY];
    logic [`RTAG_BITS-1:0]          tag_pipe  [`SDRAM_READ_LATENCY];

    // Word address modulo the array size
    assign word_index = mem_address[$clog2(`SDRAM_WORDS)+1:2];
    assign mem_ready  = (busy_count == 0);
    assign accept     = mem_request && mem_ready;

    always_ff @(posedge clock) begin
        if (reset) begin
            busy_count <= '0;
        end else if (accept) begin
            busy_count <= `SDRAM_BUSY_CYCLES;
        end else if (busy_count != 0) begin
            busy_count <= busy_count - 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (accept && mem_write) begin
            for (int b = 0; b < 4; b++) begin
                if (mem_wstrb[b]) begin
                    words[word_index][8*b +: 8] <= mem_wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[`SDRAM_READ_LATENCY-2:0], accept && !mem_write};
        end
    end

    // Data and tag shift along with the valid bits
    always_ff @(posedge clock) begin
        data_pipe[0] <= words[word_index];
        tag_pipe[0]  <= mem_tag;
        for (int s = 1; s < `SDRAM_READ_LATENCY; s++) begin
            data_pipe[s] <= data_pipe[s-1];
            tag_pipe[s]  <= tag_pipe[s-1];
        end
    end

    assign mem_rvalid = valid_pipe[`SDRAM_READ_LATENCY-1];
    assign mem_rdata  = data_pipe[`SDRAM_READ_LATENCY-1];
    assign mem_rtag   = tag_pipe[`SDRAM_READ_LATENCY-1];

endmodule

`default_nettype wire

// File: sources.f
+incdir+common
common/mem_bus_pkg.sv
dcache/cpu_dcache.sv
hdl/address_decoder.sv
sdram/sdram_arbiter.sv
sdram/sdram_memory.sv
hdl/mem_subsystem_top.sv
test/tb_mem_subsystem.sv

// File: test/tb_mem_subsystem.sv
`timescale 1ns/100ps
`default_nettype none

`include "mem_bus_settings.svh"

module tb_mem_subsystem;
    import mem_bus_pkg::*;

    localparam int TIMEOUT_CYCLES = 200;

    logic                        clock;
    logic                        reset;
    logic                        cpu_request;
    logic                        cpu_ready;
    logic                        cpu_write;
    logic [31:0]                 cpu_address;
    logic [3:0]                  cpu_wstrb;
    logic [31:0]                 cpu_wdata;
    logic                        cpu_rvalid;
    logic [31:0]                 cpu_rdata;
    logic [`RTAG_BITS-1:0]       cpu_rtag;
    logic                        icache_request;
    logic                        icache_ready;
    logic [`SDRAM_ADDR_BITS-1:0] icache_address;
    logic                        icache_rvalid;
    logic [31:0]                 icache_rdata;
    logic                        periph_rvalid;
    logic [31:0]                 periph_rdata;

    // Reference model of memory contents and of reads still in flight
    logic [31:0]           sdram_model [`SDRAM_WORDS];
    logic [31:0]           scratch_model [`PERIPH_REGS];
    logic [31:0]           data_exp_q [$];
    logic [`RTAG_BITS-1:0] tag_exp_q [$];
    logic [31:0]           inst_exp_q [$];
    logic [31:0]           written_q [$];

    int errors;
    int stall_cycles;

    mem_subsystem_top i_dut (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    function automatic mem_region_e region_of(input logic [31:0] address);
        return (address[31:26] == 6'd0) ? region_sdram :
               (address[31:26] == 6'd1) ? region_periph : region_unmapped;
    endfunction

    // Word addresses wrap around the memory
    function automatic int word_of(input logic [31:0] address);
        return int'((address >> 2) % `SDRAM_WORDS);
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  strobe);
        logic [31:0] merged;
        merged = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strobe[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

    function automatic logic [31:0] periph_expected(input logic [31:0] address);
        logic [23:0] offset;
        offset = address[25:2];
        if (region_of(address) == region_unmapped) begin
            return `UNMAPPED_DATA;
        end else if (offset < `PERIPH_REGS) begin
            return scratch_model[offset[2:0]];
        end else if (offset == `PERIPH_REGS) begin
            return `DEVICE_ID;
        end
        return 32'h0;
    endfunction

    function automatic logic [31:0] random_sdram_address();
        logic [31:0] address;
        address = $urandom();
        address[31:26] = 6'd0;
        address[1:0] = 2'd0;
        return address;
    endfunction

    function automatic logic [31:0] pick_written();
        return written_q[$urandom_range(0, written_q.size() - 1)];
    endfunction

    task automatic note_error(input string what);
        errors++;
        $display("ERROR at %0t: %s", $time, what);
    endtask

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_tag(input string name, input logic [`RTAG_BITS-1:0] expected,
                             input logic [`RTAG_BITS-1:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_region(input string name, input mem_region_e expected,
                                input mem_region_e actual);
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %0t %s expected %s actual %s", $time, name,
                     expected.name(), actual.name());
        end
    endtask

    // Read responses on either port, checked as they arrive
    always @(negedge clock) begin
        if (!reset && cpu_rvalid) begin
            if (data_exp_q.size() == 0) begin
                note_error("data read response arrived with no data read outstanding");
            end else begin
                check_tag("cpu_rtag", tag_exp_q.pop_front(), cpu_rtag);
                check_word("cpu_rdata", data_exp_q.pop_front(), cpu_rdata);
            end
        end
        if (!reset && icache_rvalid) begin
            if (inst_exp_q.size() == 0) begin
                note_error("instruction response arrived with no fetch outstanding");
            end else begin
                check_word("icache_rdata", inst_exp_q.pop_front(), icache_rdata);
            end
        end
    end

    // Returns at the accept edge with the request still driven
    task automatic send_cpu(input logic write, input logic [31:0] address,
                            input logic [3:0] wstrb, input logic [31:0] wdata);
        int waited;
        cpu_request <= 1'b1;
        cpu_write   <= write;
        cpu_address <= address;
        cpu_wstrb   <= wstrb;
        cpu_wdata   <= wdata;
        waited = 0;
        @(negedge clock);
        while (!cpu_ready && waited < TIMEOUT_CYCLES) begin
            stall_cycles++;
            waited++;
            @(negedge clock);
        end
        if (!cpu_ready) begin
            note_error("cpu_ready stayed low and the data request was never taken");
        end
        @(posedge clock);
    endtask

    task automatic send_fetch(input logic [31:0] address);
        int waited;
        icache_request <= 1'b1;
        icache_address <= address[`SDRAM_ADDR_BITS-1:0];
        waited = 0;
        @(negedge clock);
        while (!icache_ready && waited < TIMEOUT_CYCLES) begin
            waited++;
            @(negedge clock);
        end
        if (!icache_ready) begin
            note_error("icache_ready stayed low and the fetch was never taken");
        end
        @(posedge clock);
        inst_exp_q.push_back(sdram_model[word_of(address)]);
    endtask

    task automatic expect_data_read(input logic [31:0] address);
        data_exp_q.push_back(sdram_model[word_of(address)]);
        tag_exp_q.push_back({1'b0, address[9:2]});
    endtask

    // Where the router sent the request in the cycle after the accept edge
    task automatic check_route(input logic [31:0] address);
        mem_region_e seen;
        @(negedge clock);
        if (i_dut.dec_request) begin
            seen = i_dut.i_address_decoder.region;
            check_region("request route", region_of(address), seen);
        end else if (i_dut.dcache_sdram_request) begin
            seen = region_sdram;
            check_region("request route", region_of(address), seen);
        end else begin
            note_error("an accepted request went neither to SDRAM nor to the decoder");
        end
    endtask

    task automatic cpu_store(input logic [31:0] address, input logic [3:0] wstrb,
                             input logic [31:0] wdata);
        int index;
        send_cpu(1'b1, address, wstrb, wdata);
        cpu_request <= 1'b0;
        if (region_of(address) == region_sdram) begin
            index = word_of(address);
            sdram_model[index] = merge_bytes(sdram_model[index], wdata, wstrb);
            if (wstrb == 4'hf) begin
                written_q.push_back(address);
            end
        end else if (region_of(address) == region_periph && address[25:2] < `PERIPH_REGS) begin
            scratch_model[address[4:2]] = merge_bytes(scratch_model[address[4:2]], wdata, wstrb);
        end
        check_route(address);
        @(posedge clock);
    endtask

    task automatic cpu_load(input logic [31:0] address);
        logic [31:0] expected;
        send_cpu(1'b0, address, 4'h0, 32'h0);
        cpu_request <= 1'b0;
        if (region_of(address) == region_sdram) begin
            expect_data_read(address);
            check_route(address);
        end else begin
            expected = periph_expected(address);
            check_route(address);
            if (periph_rvalid) begin
                note_error("periph_rvalid came one cycle after the accept edge, too early");
            end
            @(negedge clock);
            if (!periph_rvalid) begin
                note_error("periph_rvalid missing two cycles after the accept edge");
            end else begin
                check_word("periph_rdata", expected, periph_rdata);
            end
        end
        @(posedge clock);
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while ((data_exp_q.size() != 0 || inst_exp_q.size() != 0) && waited < TIMEOUT_CYCLES) begin
            waited++;
            @(posedge clock);
        end
        if (data_exp_q.size() != 0 || inst_exp_q.size() != 0) begin
            note_error("read responses still outstanding after the timeout");
            data_exp_q.delete();
            tag_exp_q.delete();
            inst_exp_q.delete();
        end
    endtask

    task automatic reset_state_test();
        repeat (4) begin
            @(negedge clock);
            if (!cpu_ready || !icache_ready) begin
                note_error("a ready output was low right after reset");
            end
            if (cpu_rvalid || icache_rvalid || periph_rvalid) begin
                note_error("an rvalid was high before any request was made");
            end
        end
        @(posedge clock);
    endtask

    task automatic sdram_round_trip_test();
        logic [31:0] batch [$];
        logic [31:0] address;
        for (int i = 0; i < 8; i++) begin
            address = random_sdram_address();
            batch.push_back(address);
            cpu_store(address, 4'hf, $urandom());
        end
        foreach (batch[i]) begin
            cpu_load(batch[i]);
        end
        wait_drain();
    endtask

    task automatic byte_strobe_test();
        logic [31:0] address;
        for (int i = 0; i < 6; i++) begin
            address = pick_written();
            cpu_store(address, 4'($urandom_range(1, 14)), $urandom());
            cpu_load(address);
        end
        for (int r = 0; r < `PERIPH_REGS; r++) begin
            address = 32'h0400_0000 + 32'(r * 4);
            cpu_store(address, 4'hf, $urandom());
            cpu_store(address, 4'($urandom_range(1, 14)), $urandom());
            cpu_load(address);
        end
        wait_drain();
    endtask

    task automatic periph_map_test();
        logic [31:0] address;
        for (int r = 0; r < `PERIPH_REGS; r++) begin
            cpu_load(32'h0400_0000 + 32'(r * 4));
        end
        cpu_load(32'h0400_0000 + 32'(`PERIPH_REGS * 4));
        cpu_load(32'h0400_0000 + 32'((`PERIPH_REGS + 1 + $urandom_range(0, 1000)) * 4));
        address = $urandom();
        address[31:26] = 6'($urandom_range(2, 63));
        address[1:0] = 2'd0;
        cpu_load(address);
        // Unmapped write whose low bits alias scratch register 3
        address[25:2] = 24'd3;
        cpu_store(address, 4'hf, ~scratch_model[3]);
        cpu_load(32'h0400_000c);
    endtask

    task automatic back_to_back_test();
        logic [31:0] address;
        stall_cycles = 0;
        for (int i = 0; i < 12; i++) begin
            address = pick_written();
            send_cpu(1'b0, address, 4'h0, 32'h0);
            expect_data_read(address);
        end
        cpu_request <= 1'b0;
        if (stall_cycles == 0) begin
            note_error("cpu_ready never dropped during back-to-back SDRAM reads");
        end
        wait_drain();
    endtask

    task automatic arbitration_test();
        logic [31:0] data_list [6];
        logic [31:0] inst_list [6];
        for (int i = 0; i < 6; i++) begin
            data_list[i] = pick_written();
            inst_list[i] = pick_written();
        end
        // Both ports start requesting on the same edge
        fork
            begin
                for (int i = 0; i < 6; i++) begin
                    send_cpu(1'b0, data_list[i], 4'h0, 32'h0);
                    expect_data_read(data_list[i]);
                end
                cpu_request <= 1'b0;
            end
            begin
                for (int j = 0; j < 6; j++) begin
                    send_fetch(inst_list[j]);
                end
                icache_request <= 1'b0;
            end
        join
        wait_drain();
    endtask

    initial begin
        void'($urandom(32'he0c8_7061));
        errors         = 0;
        stall_cycles   = 0;
        reset          = 1'b1;
        cpu_request    = 1'b0;
        cpu_write      = 1'b0;
        cpu_address    = 32'h0;
        cpu_wstrb      = 4'h0;
        cpu_wdata      = 32'h0;
        icache_request = 1'b0;
        icache_address = '0;
        for (int r = 0; r < `PERIPH_REGS; r++) begin
            scratch_model[r] = 32'h0;
        end
        repeat (8) @(posedge clock);
        reset <= 1'b0;

        reset_state_test();
        sdram_round_trip_test();
        byte_strobe_test();
        periph_map_test();
        back_to_back_test();
        arbitration_test();

        $display("Run complete with %0d errors", errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
